//--- compile.f
src/issue_pkg.sv
src/regfile.sv
src/fust_scalar.sv
src/fust_matrix.sv
src/issue_select.sv
src/issue_stage.sv
tb/issue_stage_chk.sv
tb/issue_stage_tb.sv

//--- Makefile
# Verilator flow for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

test: $(BUILD)/V$(TOP)
	-$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/issue_stage_tb.sv
/* issue stage testbench */

`timescale 1ns/1ps

module issue_stage_tb
    import issue_pkg::*;
;

    typedef enum logic [3:0] {
        K_DISP, K_WB, K_HOLD, K_DONE, K_RDY, K_IDLE, K_DRAIN, K_CHKRDY, K_CHKVAL
    } kind_e;

    // one table row
    // a dispatch with chk set also carries an expected packet
    typedef struct packed {
        kind_e             kind;
        fu_e               fu;
        op_e               op;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] imm;
        logic [TAG_W-1:0]  t1;
        logic [TAG_W-1:0]  t2;
        logic [TAG_W-1:0]  t3;
        logic [4*MREG_W-1:0] mregs;
        logic              chk;
        logic [7:0]        val;
    } step_t;

    logic CLK, nRST;
    logic disp_valid, disp_ready;
    fu_e  disp_fu;
    op_e  disp_op;
    logic [REG_W-1:0]  disp_rs1, disp_rs2, disp_rd, wb_reg, iss_rd;
    logic [WORD_W-1:0] disp_imm, wb_data, iss_rdat1, iss_rdat2, iss_imm;
    logic [TAG_W-1:0]  disp_t1, disp_t2, disp_t3;
    logic [MREG_W-1:0] disp_md, disp_ms1, disp_ms2, disp_ms3;
    logic [MREG_W-1:0] iss_md, iss_ms1, iss_ms2, iss_ms3;
    logic wb_valid, iss_valid, iss_ready;
    fu_e  wb_fu, iss_fu;
    op_e  iss_op;
    logic [NUM_ROWS-1:0] fu_done, pending, hold;

    step_t steps[$];
    step_t exp_q[$];
    logic [WORD_W-1:0] reg_model [32];
    logic [31:0] lcg_state = 32'hf806;
    int errors = 0;
    int checked = 0;
    logic table_ready = 1'b0;
    logic seen_ready, seen_valid;

    issue_stage uut (.*);

    always #50 CLK = ~CLK;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task add_op(input fu_e fu, input op_e op, input int rs1, input int rs2, input int rd,
                input int t1, input int t2);
        step_t s;
        s = '0;
        s.kind = K_DISP;
        s.fu = fu;
        s.op = op;
        s.rs1 = REG_W'(rs1);
        s.rs2 = REG_W'(rs2);
        s.rd = REG_W'(rd);
        s.imm = lcg_next();
        s.t1 = TAG_W'(t1);
        s.t2 = TAG_W'(t2);
        s.chk = 1'b1;
        steps.push_back(s);
    endtask

    task add_gemm(input logic [4*MREG_W-1:0] mregs, input int t1, input int t2, input int t3);
        step_t s;
        s = '0;
        s.kind = K_DISP;
        s.fu = FU_GEMM;
        s.op = OP_GEMM;
        s.mregs = mregs;
        s.t1 = TAG_W'(t1);
        s.t2 = TAG_W'(t2);
        s.t3 = TAG_W'(t3);
        s.chk = 1'b1;
        steps.push_back(s);
    endtask

    task add_wb(input fu_e fu, input int r);
        step_t s;
        s = '0;
        s.kind = K_WB;
        s.fu = fu;
        s.rd = REG_W'(r);
        s.imm = lcg_next();
        steps.push_back(s);
    endtask

    task add_ctl(input kind_e k, input fu_e fu, input int val);
        step_t s;
        s = '0;
        s.kind = k;
        s.fu = fu;
        s.val = 8'(val);
        steps.push_back(s);
    endtask

    task build_table();
        // reset state
        for (int i = 0; i < NUM_ROWS; i++) add_ctl(K_CHKRDY, fu_e'(i), 1);
        add_ctl(K_CHKVAL, FU_ALU, 0);
        // operands from earlier writebacks
        // a write to r0 is dropped
        add_wb(FU_ALU, 3);
        add_wb(FU_SLS, 4);
        add_wb(FU_BR, 0);
        add_op(FU_ALU, OP_ADD, 3, 4, 5, 0, 0);
        add_op(FU_SLS, OP_LW, 0, 3, 7, 0, 0);
        add_op(FU_MLS, OP_MLD, 4, 0, 0, 0, 0);
        add_ctl(K_DRAIN, FU_ALU, 0);
        // branch waits on the alu result
        add_op(FU_BR, OP_BEQ, 6, 3, 0, 1, 0);
        add_ctl(K_IDLE, FU_ALU, 4);
        add_ctl(K_CHKVAL, FU_ALU, 0);
        add_wb(FU_ALU, 6);
        add_ctl(K_DRAIN, FU_ALU, 0);
        // two rows woken by one writeback issue older first
        add_op(FU_BR, OP_BNE, 3, 4, 0, 2, 0);
        add_op(FU_ALU, OP_SUB, 4, 3, 8, 2, 0);
        add_wb(FU_SLS, 9);
        add_ctl(K_DRAIN, FU_ALU, 0);
        // back-pressure
        add_ctl(K_RDY, FU_ALU, 0);
        add_op(FU_SLS, OP_SW, 3, 4, 0, 0, 0);
        add_op(FU_ALU, OP_AND, 3, 9, 10, 0, 0);
        add_op(FU_BR, OP_BEQ, 9, 4, 0, 0, 0);
        add_ctl(K_IDLE, FU_ALU, 4);
        add_ctl(K_CHKVAL, FU_ALU, 1);
        add_ctl(K_RDY, FU_ALU, 1);
        add_ctl(K_DRAIN, FU_ALU, 0);
        // occupied row until done
        add_ctl(K_HOLD, FU_ALU, 0);
        add_op(FU_ALU, OP_OR, 3, 4, 11, 0, 0);
        add_ctl(K_DRAIN, FU_ALU, 0);
        add_ctl(K_CHKRDY, FU_ALU, 0);
        add_ctl(K_DONE, FU_ALU, 0);
        add_ctl(K_IDLE, FU_ALU, 2);
        add_ctl(K_CHKRDY, FU_ALU, 1);
        // gemm needs all three producers
        add_gemm({4'd1, 4'd2, 4'd3, 4'd4}, 1, 2, 3);
        add_wb(FU_ALU, 12);
        add_wb(FU_SLS, 13);
        add_ctl(K_IDLE, FU_ALU, 3);
        add_ctl(K_CHKVAL, FU_ALU, 0);
        add_wb(FU_BR, 14);
        add_ctl(K_DRAIN, FU_ALU, 0);
    endtask

    task check_bit(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_packet(input fu_e efu, input op_e eop, input logic [REG_W-1:0] erd,
                      input logic [WORD_W-1:0] ed1, input logic [WORD_W-1:0] ed2,
                      input logic [WORD_W-1:0] eimm, input logic [4*MREG_W-1:0] em);
        checked++;
        if (iss_fu !== efu || iss_op !== eop || iss_rd !== erd || iss_rdat1 !== ed1 ||
                iss_rdat2 !== ed2 || iss_imm !== eimm ||
                {iss_md, iss_ms1, iss_ms2, iss_ms3} !== em) begin
            errors++;
            $display("** Error @ %0t: packet %s/%s rd %0d d %h %h imm %h m %h",
                     $time, iss_fu.name(), iss_op.name(), iss_rd, iss_rdat1, iss_rdat2,
                     iss_imm, {iss_md, iss_ms1, iss_ms2, iss_ms3});
            $display("    expected %s/%s rd %0d d %h %h imm %h m %h",
                     efu.name(), eop.name(), erd, ed1, ed2, eimm, em);
        end
    endtask

    // sample at the falling edge and drive done pulses after the rising one
    task tick();
        step_t e;
        logic gemm;
        @(negedge CLK);
        seen_ready = disp_ready;
        seen_valid = iss_valid;
        if (iss_valid && iss_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected packet issued at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                gemm = e.fu == FU_GEMM;
                check_packet(e.fu, e.op, (e.fu < FU_MLS) ? e.rd : '0,
                             gemm ? '0 : reg_model[e.rs1], gemm ? '0 : reg_model[e.rs2],
                             gemm ? '0 : e.imm, gemm ? e.mregs : '0);
            end
            pending[iss_fu] = 1'b1;
        end
        @(posedge CLK);
        #10;
        fu_done = pending & ~hold;
        pending = pending & hold;
    endtask

    task run_step(input step_t s);
        case (s.kind)
            K_DISP: begin
                disp_valid = 1'b1;
                disp_fu = s.fu;
                disp_op = s.op;
                disp_rs1 = s.rs1;
                disp_rs2 = s.rs2;
                disp_rd = s.rd;
                disp_imm = s.imm;
                disp_t1 = s.t1;
                disp_t2 = s.t2;
                disp_t3 = s.t3;
                {disp_md, disp_ms1, disp_ms2, disp_ms3} = s.mregs;
                do tick(); while (!seen_ready);
                disp_valid = 1'b0;
                if (s.chk) exp_q.push_back(s);
            end
            K_WB: begin
                wb_valid = 1'b1;
                wb_fu = s.fu;
                wb_reg = s.rd;
                wb_data = s.imm;
                tick();
                wb_valid = 1'b0;
                if (s.rd != '0) reg_model[s.rd] = s.imm;
            end
            K_HOLD: hold[s.fu] = 1'b1;
            K_DONE: begin
                hold[s.fu] = 1'b0;
                tick();
            end
            K_RDY: begin
                iss_ready = s.val[0];
                tick();
            end
            K_IDLE: repeat (s.val) tick();
            K_DRAIN: begin
                while (exp_q.size() != 0) tick();
                tick();
            end
            K_CHKRDY: begin
                disp_fu = s.fu;
                tick();
                check_bit(s.val[0], seen_ready, $sformatf("disp_ready for %s", s.fu.name()));
            end
            default: begin
                tick();
                check_bit(s.val[0], seen_valid, "iss_valid");
            end
        endcase
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        disp_valid = 1'b0;
        disp_fu = FU_ALU;
        disp_op = OP_ADD;
        {disp_rs1, disp_rs2, disp_rd, disp_imm} = '0;
        {disp_t1, disp_t2, disp_t3} = '0;
        {disp_md, disp_ms1, disp_ms2, disp_ms3} = '0;
        wb_valid = 1'b0;
        wb_fu = FU_ALU;
        wb_reg = '0;
        wb_data = '0;
        fu_done = '0;
        pending = '0;
        hold = '0;
        iss_ready = 1'b1;
        for (int i = 0; i < 32; i++) reg_model[i] = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge CLK);
        #10 nRST = 1'b1;
        foreach (steps[i]) run_step(steps[i]);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected packets never issued", exp_q.size());
        end
        $display("errors: %0d, packets checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #(steps.size() * 20 * 100);
        $display("Timeout: the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb/issue_stage_chk.sv
/* issue stage assertions */

`timescale 1ns/1ps

module issue_stage_chk
    import issue_pkg::*;
(
    input logic                CLK,
    input logic                nRST,
    input logic                disp_valid,
    input logic                disp_ready,
    input fu_e                 disp_fu,
    input logic [NUM_ROWS-1:0] fu_done,
    input logic [NUM_ROWS-1:0] grant,
    input logic                iss_valid,
    input logic                iss_ready,
    input logic [WORD_W*3+4*MREG_W+REG_W+6:0] pkt
);

    logic [NUM_ROWS-1:0] busy;

    // a row is busy from its accept until its unit reports done
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            busy <= '0;
        else
            busy <= (busy & ~fu_done) |
                    ((disp_valid && disp_ready) ? (NUM_ROWS'(1) << disp_fu) : '0);
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(grant))
        else $error("grant has more than one bit set");

    a_packet_hold: assert property (@(posedge CLK) disable iff (!nRST)
        iss_valid && !iss_ready |=> iss_valid && $stable(pkt))
        else $error("issue packet changed under back-pressure");

    a_ready_busy: assert property (@(posedge CLK) disable iff (!nRST)
        disp_ready |-> !busy[disp_fu])
        else $error("disp_ready high for a busy row");

endmodule

bind issue_stage issue_stage_chk u_chk (
    .CLK(CLK), .nRST(nRST), .disp_valid(disp_valid), .disp_ready(disp_ready),
    .disp_fu(disp_fu), .fu_done(fu_done), .grant(grant), .iss_valid(iss_valid),
    .iss_ready(iss_ready),
    .pkt({iss_fu, iss_op, iss_rd, iss_rdat1, iss_rdat2, iss_imm,
          iss_md, iss_ms1, iss_ms2, iss_ms3})
);

//--- src/issue_stage.sv
/* issue stage top */

`timescale 1ns/1ps

module issue_stage
    import issue_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  fu_e                 disp_fu,
    input  op_e                 disp_op,
    input  logic [REG_W-1:0]    disp_rs1,
    input  logic [REG_W-1:0]    disp_rs2,
    input  logic [REG_W-1:0]    disp_rd,
    input  logic [WORD_W-1:0]   disp_imm,
    input  logic [TAG_W-1:0]    disp_t1,
    input  logic [TAG_W-1:0]    disp_t2,
    input  logic [TAG_W-1:0]    disp_t3,
    input  logic [MREG_W-1:0]   disp_md,
    input  logic [MREG_W-1:0]   disp_ms1,
    input  logic [MREG_W-1:0]   disp_ms2,
    input  logic [MREG_W-1:0]   disp_ms3,
    input  logic                wb_valid,
    input  fu_e                 wb_fu,
    input  logic [REG_W-1:0]    wb_reg,
    input  logic [WORD_W-1:0]   wb_data,
    input  logic [NUM_ROWS-1:0] fu_done,
    output logic                iss_valid,
    input  logic                iss_ready,
    output fu_e                 iss_fu,
    output op_e                 iss_op,
    output logic [REG_W-1:0]    iss_rd,
    output logic [WORD_W-1:0]   iss_rdat1,
    output logic [WORD_W-1:0]   iss_rdat2,
    output logic [WORD_W-1:0]   iss_imm,
    output logic [MREG_W-1:0]   iss_md,
    output logic [MREG_W-1:0]   iss_ms1,
    output logic [MREG_W-1:0]   iss_ms2,
    output logic [MREG_W-1:0]   iss_ms3
);

    logic                             scal_disp_ready, mat_disp_ready, disp_fire;
    logic [NUM_ROWS-1:0]              grant;
    logic [NUM_SROWS-1:0]             scal_req;
    logic [NUM_MROWS-1:0]             mat_req;
    logic [NUM_SROWS-1:0][AGE_W-1:0]  scal_age;
    logic [NUM_MROWS-1:0][AGE_W-1:0]  mat_age;
    op_e  [NUM_SROWS-1:0]             scal_op;
    op_e  [NUM_MROWS-1:0]             mat_op;
    logic [NUM_SROWS-1:0][REG_W-1:0]  scal_rs1, scal_rs2, scal_rd;
    logic [NUM_SROWS-1:0][WORD_W-1:0] scal_imm;
    logic [REG_W-1:0]                 mls_rs1, mls_rs2, rsel1, rsel2;
    logic [WORD_W-1:0]                mls_imm, rdat1, rdat2;
    logic [MREG_W-1:0]                gemm_md, gemm_ms1, gemm_ms2, gemm_ms3;

    // each table answers only for its own rows
    assign disp_ready = scal_disp_ready | mat_disp_ready;
    assign disp_fire  = disp_valid & disp_ready;

    fust_scalar u_fust_scalar (
        .CLK, .nRST, .disp_fire, .disp_fu, .disp_op, .disp_rs1, .disp_rs2, .disp_rd,
        .disp_imm, .disp_t1, .disp_t2, .wb_valid, .wb_fu,
        .fu_done(fu_done[NUM_SROWS-1:0]), .grant(grant[NUM_SROWS-1:0]),
        .scal_disp_ready, .row_req(scal_req), .row_age(scal_age), .row_op(scal_op),
        .row_rs1(scal_rs1), .row_rs2(scal_rs2), .row_rd(scal_rd), .row_imm(scal_imm)
    );

    fust_matrix u_fust_matrix (
        .CLK, .nRST, .disp_fire, .disp_fu, .disp_op, .disp_rs1, .disp_rs2, .disp_imm,
        .disp_t1, .disp_t2, .disp_t3, .disp_md, .disp_ms1, .disp_ms2, .disp_ms3,
        .wb_valid, .wb_fu,
        .fu_done(fu_done[NUM_ROWS-1:NUM_SROWS]), .grant(grant[NUM_ROWS-1:NUM_SROWS]),
        .mat_disp_ready, .row_req(mat_req), .row_age(mat_age), .row_op(mat_op),
        .mls_rs1, .mls_rs2, .mls_imm, .gemm_md, .gemm_ms1, .gemm_ms2, .gemm_ms3
    );

    issue_select u_issue_select (
        .CLK, .nRST, .row_req({mat_req, scal_req}), .row_age({mat_age, scal_age}),
        .scal_op, .scal_rs1, .scal_rs2, .scal_rd, .scal_imm, .mat_op,
        .mls_rs1, .mls_rs2, .mls_imm, .gemm_md, .gemm_ms1, .gemm_ms2, .gemm_ms3,
        .rdat1, .rdat2, .iss_ready, .grant, .rsel1, .rsel2,
        .iss_valid, .iss_fu, .iss_op, .iss_rd, .iss_rdat1, .iss_rdat2, .iss_imm,
        .iss_md, .iss_ms1, .iss_ms2, .iss_ms3
    );

    regfile u_regfile (
        .CLK, .nRST, .wen(wb_valid), .wsel(wb_reg), .wdata(wb_data),
        .rsel1, .rsel2, .rdat1, .rdat2
    );

endmodule

//--- src/issue_select.sv
/* oldest-first issue selector */

`timescale 1ns/1ps

module issue_select
    import issue_pkg::*;
(
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [NUM_ROWS-1:0]                 row_req,
    input  logic [NUM_ROWS-1:0][AGE_W-1:0]      row_age,
    input  op_e  [NUM_SROWS-1:0]                scal_op,
    input  logic [NUM_SROWS-1:0][REG_W-1:0]     scal_rs1,
    input  logic [NUM_SROWS-1:0][REG_W-1:0]     scal_rs2,
    input  logic [NUM_SROWS-1:0][REG_W-1:0]     scal_rd,
    input  logic [NUM_SROWS-1:0][WORD_W-1:0]    scal_imm,
    input  op_e  [NUM_MROWS-1:0]                mat_op,
    input  logic [REG_W-1:0]                    mls_rs1,
    input  logic [REG_W-1:0]                    mls_rs2,
    input  logic [WORD_W-1:0]                   mls_imm,
    input  logic [MREG_W-1:0]                   gemm_md,
    input  logic [MREG_W-1:0]                   gemm_ms1,
    input  logic [MREG_W-1:0]                   gemm_ms2,
    input  logic [MREG_W-1:0]                   gemm_ms3,
    input  logic [WORD_W-1:0]                   rdat1,
    input  logic [WORD_W-1:0]                   rdat2,
    input  logic                                iss_ready,
    output logic [NUM_ROWS-1:0]                 grant,
    output logic [REG_W-1:0]                    rsel1,
    output logic [REG_W-1:0]                    rsel2,
    output logic                                iss_valid,
    output fu_e                                 iss_fu,
    output op_e                                 iss_op,
    output logic [REG_W-1:0]                    iss_rd,
    output logic [WORD_W-1:0]                   iss_rdat1,
    output logic [WORD_W-1:0]                   iss_rdat2,
    output logic [WORD_W-1:0]                   iss_imm,
    output logic [MREG_W-1:0]                   iss_md,
    output logic [MREG_W-1:0]                   iss_ms1,
    output logic [MREG_W-1:0]                   iss_ms2,
    output logic [MREG_W-1:0]                   iss_ms3
);

    logic             found;
    logic [2:0]       best;
    logic [AGE_W-1:0] best_age;
    logic             take;
    fu_e              best_fu;
    op_e              sel_op;
    logic [REG_W-1:0] sel_rd;
    logic [WORD_W-1:0] sel_imm;

    // strict compare keeps the lower index on a tie
    always_comb begin
        found    = 1'b0;
        best     = '0;
        best_age = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_req[i] && (!found || row_age[i] > best_age)) begin
                found    = 1'b1;
                best     = 3'(i);
                best_age = row_age[i];
            end
        end
    end

    // no grant while a stalled packet sits in the register
    assign take    = found && (!iss_valid || iss_ready);
    assign best_fu = fu_e'(best);

    always_comb begin
        grant = '0;
        if (take)
            grant[best] = 1'b1;
    end

    always_comb begin
        rsel1   = '0;
        rsel2   = '0;
        sel_rd  = '0;
        sel_imm = '0;
        sel_op  = mat_op[1];
        case (best_fu)
            FU_MLS: begin
                rsel1   = mls_rs1;
                rsel2   = mls_rs2;
                sel_imm = mls_imm;
                sel_op  = mat_op[0];
            end
            FU_GEMM: ;
            default: begin
                rsel1   = scal_rs1[best[1:0]];
                rsel2   = scal_rs2[best[1:0]];
                sel_rd  = scal_rd[best[1:0]];
                sel_imm = scal_imm[best[1:0]];
                sel_op  = scal_op[best[1:0]];
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            iss_valid <= 1'b0;
        else if (take)
            iss_valid <= 1'b1;
        else if (iss_ready)
            iss_valid <= 1'b0;
    end

    // gemm carries matrix fields only, scalar data goes out as zero
    always_ff @(posedge CLK) begin
        if (take) begin
            iss_fu    <= best_fu;
            iss_op    <= sel_op;
            iss_rd    <= sel_rd;
            iss_rdat1 <= (best_fu == FU_GEMM) ? '0 : rdat1;
            iss_rdat2 <= (best_fu == FU_GEMM) ? '0 : rdat2;
            iss_imm   <= sel_imm;
            iss_md    <= (best_fu == FU_GEMM) ? gemm_md  : '0;
            iss_ms1   <= (best_fu == FU_GEMM) ? gemm_ms1 : '0;
            iss_ms2   <= (best_fu == FU_GEMM) ? gemm_ms2 : '0;
            iss_ms3   <= (best_fu == FU_GEMM) ? gemm_ms3 : '0;
        end
    end

endmodule

//--- src/fust_matrix.sv
/* matrix function unit status table */

`timescale 1ns/1ps

module fust_matrix
    import issue_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            disp_fire,
    input  fu_e                             disp_fu,
    input  op_e                             disp_op,
    input  logic [REG_W-1:0]                disp_rs1,
    input  logic [REG_W-1:0]                disp_rs2,
    input  logic [WORD_W-1:0]               disp_imm,
    input  logic [TAG_W-1:0]                disp_t1,
    input  logic [TAG_W-1:0]                disp_t2,
    input  logic [TAG_W-1:0]                disp_t3,
    input  logic [MREG_W-1:0]               disp_md,
    input  logic [MREG_W-1:0]               disp_ms1,
    input  logic [MREG_W-1:0]               disp_ms2,
    input  logic [MREG_W-1:0]               disp_ms3,
    input  logic                            wb_valid,
    input  fu_e                             wb_fu,
    input  logic [NUM_MROWS-1:0]            fu_done,
    input  logic [NUM_MROWS-1:0]            grant,
    output logic                            mat_disp_ready,
    output logic [NUM_MROWS-1:0]            row_req,
    output logic [NUM_MROWS-1:0][AGE_W-1:0] row_age,
    output op_e  [NUM_MROWS-1:0]            row_op,
    output logic [REG_W-1:0]                mls_rs1,
    output logic [REG_W-1:0]                mls_rs2,
    output logic [WORD_W-1:0]               mls_imm,
    output logic [MREG_W-1:0]               gemm_md,
    output logic [MREG_W-1:0]               gemm_ms1,
    output logic [MREG_W-1:0]               gemm_ms2,
    output logic [MREG_W-1:0]               gemm_ms3
);

    // row 0 is matrix load/store, row 1 is gemm
    row_state_e [NUM_MROWS-1:0]                 state;
    logic       [NUM_MROWS-1:0][2:0][TAG_W-1:0] tag;
    logic       [NUM_MROWS-1:0]                 accept;

    always_comb begin
        for (int i = 0; i < NUM_MROWS; i++) begin
            accept[i]  = disp_fire && disp_fu == fu_e'(NUM_SROWS + i);
            row_req[i] = state[i] == ROW_RDY;
        end
    end

    assign mat_disp_ready = (disp_fu == FU_MLS || disp_fu == FU_GEMM) &&
                            state[disp_fu == FU_GEMM] == ROW_EMPTY;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_MROWS; i++) begin
                state[i]   <= ROW_EMPTY;
                tag[i]     <= '0;
                row_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_MROWS; i++) begin
                for (int k = 0; k < 3; k++) begin
                    tag[i][k] <= tag_clr(tag[i][k], wb_valid, wb_fu);
                end
                if (disp_fire && state[i] != ROW_EMPTY && state[i] != ROW_EX &&
                        row_age[i] != AGE_MAX)
                    row_age[i] <= row_age[i] + AGE_W'(1);
                case (state[i])
                    ROW_EMPTY: begin
                        if (accept[i]) begin
                            state[i]     <= ROW_WAIT;
                            tag[i][0]    <= tag_clr(disp_t1, wb_valid, wb_fu);
                            tag[i][1]    <= tag_clr(disp_t2, wb_valid, wb_fu);
                            // load/store has no third operand
                            tag[i][2]    <= (i == 0) ? '0 : tag_clr(disp_t3, wb_valid, wb_fu);
                            row_age[i]   <= AGE_W'(1);
                        end
                    end
                    ROW_WAIT: begin
                        if (tag[i] == '0)
                            state[i] <= ROW_RDY;
                    end
                    ROW_RDY: begin
                        if (grant[i]) begin
                            state[i]   <= ROW_EX;
                            row_age[i] <= '0;
                        end
                    end
                    ROW_EX: begin
                        if (fu_done[i])
                            state[i] <= ROW_EMPTY;
                    end
                    default: state[i] <= ROW_EMPTY;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_MROWS; i++) begin
            if (accept[i] && state[i] == ROW_EMPTY)
                row_op[i] <= disp_op;
        end
        if (accept[0] && state[0] == ROW_EMPTY) begin
            mls_rs1 <= disp_rs1;
            mls_rs2 <= disp_rs2;
            mls_imm <= disp_imm;
        end
        if (accept[1] && state[1] == ROW_EMPTY) begin
            gemm_md  <= disp_md;
            gemm_ms1 <= disp_ms1;
            gemm_ms2 <= disp_ms2;
            gemm_ms3 <= disp_ms3;
        end
    end

endmodule

//--- src/fust_scalar.sv
/* scalar function unit status table */

`timescale 1ns/1ps

module fust_scalar
    import issue_pkg::*;
(
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                disp_fire,
    input  fu_e                                 disp_fu,
    input  op_e                                 disp_op,
    input  logic [REG_W-1:0]                    disp_rs1,
    input  logic [REG_W-1:0]                    disp_rs2,
    input  logic [REG_W-1:0]                    disp_rd,
    input  logic [WORD_W-1:0]                   disp_imm,
    input  logic [TAG_W-1:0]                    disp_t1,
    input  logic [TAG_W-1:0]                    disp_t2,
    input  logic                                wb_valid,
    input  fu_e                                 wb_fu,
    input  logic [NUM_SROWS-1:0]                fu_done,
    input  logic [NUM_SROWS-1:0]                grant,
    output logic                                scal_disp_ready,
    output logic [NUM_SROWS-1:0]                row_req,
    output logic [NUM_SROWS-1:0][AGE_W-1:0]     row_age,
    output op_e  [NUM_SROWS-1:0]                row_op,
    output logic [NUM_SROWS-1:0][REG_W-1:0]     row_rs1,
    output logic [NUM_SROWS-1:0][REG_W-1:0]     row_rs2,
    output logic [NUM_SROWS-1:0][REG_W-1:0]     row_rd,
    output logic [NUM_SROWS-1:0][WORD_W-1:0]    row_imm
);

    row_state_e [NUM_SROWS-1:0]             state;
    logic       [NUM_SROWS-1:0][TAG_W-1:0]  t1;
    logic       [NUM_SROWS-1:0][TAG_W-1:0]  t2;
    logic       [NUM_SROWS-1:0]             accept;

    always_comb begin
        for (int i = 0; i < NUM_SROWS; i++) begin
            accept[i]  = disp_fire && disp_fu == fu_e'(i);
            row_req[i] = state[i] == ROW_RDY;
        end
    end

    // the index is only looked at once disp_fu is known to be scalar
    assign scal_disp_ready = (disp_fu < FU_MLS) && state[disp_fu[1:0]] == ROW_EMPTY;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_SROWS; i++) begin
                state[i]   <= ROW_EMPTY;
                t1[i]      <= '0;
                t2[i]      <= '0;
                row_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SROWS; i++) begin
                t1[i] <= tag_clr(t1[i], wb_valid, wb_fu);
                t2[i] <= tag_clr(t2[i], wb_valid, wb_fu);
                if (disp_fire && state[i] != ROW_EMPTY && state[i] != ROW_EX &&
                        row_age[i] != AGE_MAX)
                    row_age[i] <= row_age[i] + AGE_W'(1);
                case (state[i])
                    ROW_EMPTY: begin
                        if (accept[i]) begin
                            state[i]   <= ROW_WAIT;
                            t1[i]      <= tag_clr(disp_t1, wb_valid, wb_fu);
                            t2[i]      <= tag_clr(disp_t2, wb_valid, wb_fu);
                            row_age[i] <= AGE_W'(1);
                        end
                    end
                    ROW_WAIT: begin
                        if (t1[i] == '0 && t2[i] == '0)
                            state[i] <= ROW_RDY;
                    end
                    ROW_RDY: begin
                        if (grant[i]) begin
                            state[i]   <= ROW_EX;
                            row_age[i] <= '0;
                        end
                    end
                    ROW_EX: begin
                        if (fu_done[i])
                            state[i] <= ROW_EMPTY;
                    end
                    default: state[i] <= ROW_EMPTY;
                endcase
            end
        end
    end

    // operand fields, loaded on accept
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_SROWS; i++) begin
            if (accept[i] && state[i] == ROW_EMPTY) begin
                row_op[i]  <= disp_op;
                row_rs1[i] <= disp_rs1;
                row_rs2[i] <= disp_rs2;
                row_rd[i]  <= disp_rd;
                row_imm[i] <= disp_imm;
            end
        end
    end

endmodule

//--- src/regfile.sv
/* scalar register file */

`timescale 1ns/1ps

module regfile
    import issue_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              wen,
    input  logic [REG_W-1:0]  wsel,
    input  logic [WORD_W-1:0] wdata,
    input  logic [REG_W-1:0]  rsel1,
    input  logic [REG_W-1:0]  rsel2,
    output logic [WORD_W-1:0] rdat1,
    output logic [WORD_W-1:0] rdat2
);

    logic [WORD_W-1:0] regs [2**REG_W];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            // r0 is never written, so it keeps reading zero
            regs[wsel] <= wdata;
        end
    end

    // no bypass: a write is seen on the cycle after
    assign rdat1 = regs[rsel1];
    assign rdat2 = regs[rsel2];

endmodule

//--- src/issue_pkg.sv
/* issue stage shared types */

package issue_pkg;

    // sizes fixed by the instruction set
    localparam int NUM_ROWS  = 5;
    localparam int NUM_SROWS = 3;
    localparam int NUM_MROWS = NUM_ROWS - NUM_SROWS;
    localparam int WORD_W    = 32;
    localparam int REG_W     = 5;
    localparam int MREG_W    = 4;
    localparam int TAG_W     = 3;
    localparam int AGE_W     = 3;

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    // unit names double as row index
    typedef enum logic [2:0] {
        FU_ALU  = 3'd0,
        FU_SLS  = 3'd1,
        FU_BR   = 3'd2,
        FU_MLS  = 3'd3,
        FU_GEMM = 3'd4
    } fu_e;

    typedef enum logic [1:0] {
        ROW_EMPTY = 2'd0,
        ROW_WAIT  = 2'd1,
        ROW_RDY   = 2'd2,
        ROW_EX    = 2'd3
    } row_state_e;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE,
        OP_MLD, OP_MST, OP_GEMM
    } op_e;

    // a tag holds the producer's index plus one, zero once written back
    function automatic logic [TAG_W-1:0] tag_clr(
        input logic [TAG_W-1:0] tag,
        input logic             wb_valid,
        input fu_e              wb_fu
    );
        if (wb_valid && tag == TAG_W'(wb_fu) + TAG_W'(1))
            return '0;
        return tag;
    endfunction

endpackage
